/* hdl/ctrl_stage_fsm.sv */
`timescale 1ns/1ps
`default_nettype none

module ctrl_stage_fsm (
  input  logic                      clk,
  input  logic                      reset,
  input  usb_ctrl_pkg::out_ep_t     out_ep,
  input  usb_ctrl_pkg::in_ep_t      in_ep,
  input  usb_ctrl_pkg::setup_pkt_t  setup,
  input  logic                      all_sent,
  input  logic                      stall,
  output usb_ctrl_pkg::ctrl_stage_e stage,
  output logic                      setup_done,
  output logic                      status_done,
  output logic                      zlp
);

  usb_ctrl_pkg::ctrl_stage_e stage_next;
  logic        avail_q;
  logic        pkt_start;
  logic        pkt_end;
  logic        has_data;
  logic [15:0] out_cnt;   // OUT data bytes still expected

  // packet edges on the OUT endpoint
  always_ff @(posedge clk) begin
    if (reset) begin
      avail_q <= 1'b0;
    end else begin
      avail_q <= out_ep.data_avail;
    end
  end

  assign pkt_start = out_ep.data_avail && !avail_q;
  assign pkt_end = !out_ep.data_avail && avail_q;
  assign has_data = setup.w_length != 16'd0;

  always_ff @(posedge clk) begin
    if (setup_done) begin
      out_cnt <= setup.w_length;
    end else if (stage == usb_ctrl_pkg::DATA_OUT && out_ep.grant && out_ep.data_avail &&
                 !out_ep.setup) begin
      out_cnt <= out_cnt - 16'd1;   // byte taken and dropped
    end
  end

  ////////////////////////////////////////
  // stage sequencing
  ////////////////////////////////////////

  always_comb begin
    stage_next = stage;
    setup_done = 1'b0;
    status_done = 1'b0;
    zlp = 1'b0;
    case (stage)
      usb_ctrl_pkg::IDLE: begin
        if (pkt_start && out_ep.setup) stage_next = usb_ctrl_pkg::SETUP_IN;
      end
      usb_ctrl_pkg::SETUP_IN: begin
        if (pkt_end) stage_next = usb_ctrl_pkg::SETUP_DONE;
      end
      usb_ctrl_pkg::SETUP_DONE: begin
        setup_done = 1'b1;
        if (has_data && setup.bm_request_type[7]) begin
          stage_next = usb_ctrl_pkg::DATA_IN;
        end else if (has_data) begin
          stage_next = usb_ctrl_pkg::DATA_OUT;
        end else begin
          stage_next = usb_ctrl_pkg::STATUS_IN;
          zlp = 1'b1;   // no data stage, answer with empty packet
        end
      end
      usb_ctrl_pkg::DATA_IN: begin
        if (stall) begin
          stage_next = usb_ctrl_pkg::IDLE;
          status_done = 1'b1;
        end else if (in_ep.acked && all_sent) begin
          stage_next = usb_ctrl_pkg::STATUS_OUT;
        end
      end
      usb_ctrl_pkg::DATA_OUT: begin
        if (stall) begin
          stage_next = usb_ctrl_pkg::IDLE;
          status_done = 1'b1;
        end else if (out_cnt == 16'd0) begin
          stage_next = usb_ctrl_pkg::STATUS_IN;
          zlp = 1'b1;
        end
      end
      usb_ctrl_pkg::STATUS_IN: begin
        if (stall || in_ep.acked) begin
          stage_next = usb_ctrl_pkg::IDLE;
          status_done = 1'b1;
        end
      end
      usb_ctrl_pkg::STATUS_OUT: begin
        if (out_ep.acked) begin
          stage_next = usb_ctrl_pkg::IDLE;
          status_done = 1'b1;
        end
      end
      default: stage_next = usb_ctrl_pkg::IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      stage <= usb_ctrl_pkg::IDLE;
    end else begin
      stage <= stage_next;
    end
  end

endmodule

`default_nettype wire

/* hdl/dfu_pkg.sv */
`default_nettype none

package dfu_pkg;

  typedef enum logic [7:0] {
    REQ_DETACH    = 8'h00,
    REQ_DNLOAD    = 8'h01,
    REQ_UPLOAD    = 8'h02,
    REQ_GETSTATUS = 8'h03,
    REQ_CLRSTATUS = 8'h04,
    REQ_GETSTATE  = 8'h05,
    REQ_ABORT     = 8'h06
  } dfu_request_e;

  typedef enum logic [7:0] {
    APP_IDLE                = 8'h00,
    APP_DETACH              = 8'h01,
    DFU_IDLE                = 8'h02,
    DFU_DNLOAD_SYNC         = 8'h03,
    DFU_DNBUSY              = 8'h04,
    DFU_DNLOAD_IDLE         = 8'h05,
    DFU_MANIFEST_SYNC       = 8'h06,
    DFU_MANIFEST            = 8'h07,
    DFU_MANIFEST_WAIT_RESET = 8'h08,
    DFU_UPLOAD_IDLE         = 8'h09,
    DFU_ERROR               = 8'h0a
  } dfu_state_e;

  typedef enum logic [7:0] {
    STATUS_OK,        ERR_TARGET,   ERR_FILE,     ERR_WRITE,
    ERR_ERASE,        ERR_CHECK_ERASED, ERR_PROG, ERR_VERIFY,
    ERR_ADDRESS,      ERR_NOTDONE,  ERR_FIRMWARE, ERR_VENDOR,
    ERR_USBR,         ERR_POR,      ERR_UNKNOWN,  ERR_STALLEDPKT
  } dfu_status_e;

  // bStatus and bState of the GETSTATUS reply
  typedef struct packed {
    dfu_status_e b_status;
    dfu_state_e  b_state;
  } dfu_status_rec_t;

endpackage

`default_nettype wire

/* hdl/dfu_request_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module dfu_request_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  usb_ctrl_pkg::setup_pkt_t setup,
  input  logic                     setup_done,
  output usb_ctrl_pkg::reply_req_t reply,
  output dfu_pkg::dfu_status_rec_t status
);

  dfu_pkg::dfu_request_e req;
  logic [15:0] full_len;

  assign req = dfu_pkg::dfu_request_e'(setup.b_request);

  always_comb begin
    reply = '0;
    full_len = 16'd0;
    reply.claim = setup.bm_request_type[6:5] == 2'b01;   // type class
    reply.src = usb_ctrl_pkg::SRC_DFU;
    case (req)
      dfu_pkg::REQ_GETSTATUS: full_len = 16'd6;
      dfu_pkg::REQ_GETSTATE: begin
        reply.start_addr = 8'd4;   // bState byte of the status record
        full_len = 16'd1;
      end
      dfu_pkg::REQ_DNLOAD,
      dfu_pkg::REQ_UPLOAD: reply.stall = 1'b1;   // no firmware path
      default: full_len = 16'd0;
    endcase
    reply.length = (full_len > setup.w_length) ? setup.w_length : full_len;
  end

  ////////////////////////////////////////
  // dfu state and status
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      status.b_status <= dfu_pkg::STATUS_OK;
      status.b_state <= dfu_pkg::DFU_IDLE;
    end else if (setup_done && reply.claim) begin
      case (req)
        dfu_pkg::REQ_CLRSTATUS: begin
          status.b_status <= dfu_pkg::STATUS_OK;
          status.b_state <= dfu_pkg::DFU_IDLE;
        end
        dfu_pkg::REQ_ABORT: status.b_state <= dfu_pkg::DFU_IDLE;
        dfu_pkg::REQ_DNLOAD,
        dfu_pkg::REQ_UPLOAD: begin
          status.b_status <= dfu_pkg::ERR_STALLEDPKT;
          status.b_state <= dfu_pkg::DFU_ERROR;
        end
        default: status <= status;
      endcase
    end
  end

endmodule

`default_nettype wire

/* hdl/reply_streamer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_defines.svh"

module reply_streamer (
  input  logic                      clk,
  input  logic                      reset,
  input  usb_ctrl_pkg::ctrl_stage_e stage,
  input  logic                      setup_done,
  input  logic                      zlp,
  input  usb_ctrl_pkg::reply_req_t  std_reply,
  input  usb_ctrl_pkg::reply_req_t  dfu_reply,
  input  dfu_pkg::dfu_status_rec_t  dfu_status,
  input  usb_ctrl_pkg::in_ep_t      in_ep,
  output logic                      all_sent,
  output logic                      stall,
  output logic                      in_ep_req,
  output logic                      in_ep_data_put,
  output logic [7:0]                in_ep_data,
  output logic                      in_ep_data_done
);

  localparam int EP_IMG_LEN = `DESC_LANG_OFS + `DESC_LANG_LEN;

  // device, configuration/interface/dfu functional, language id
  localparam logic [8*EP_IMG_LEN-1:0] EP_IMG = {
    8'd18, 8'd1, 8'h00, 8'h01, 8'h00, 8'h00, 8'h00, 8'(`USB_MAX_PKT),
    8'h50, 8'h1d, 8'h30, 8'h61, 8'h00, 8'h00, 8'd1, 8'd2, 8'd3, 8'd1,
    8'd9, 8'd2, 8'(`DESC_CFG_LEN), 8'd0, 8'd1, 8'd1, 8'd0, 8'hc0, 8'd50,
    8'd9, 8'd4, 8'd0, 8'd0, 8'd0, 8'hfe, 8'd1, 8'd2, 8'd4,   // dfu mode interface
    8'd9, 8'h21, 8'h0b, 8'd255, 8'd0, 8'(`DFU_XFER_SIZE), 8'(`DFU_XFER_SIZE >> 8),
    8'h10, 8'h01,
    8'd4, 8'd3, 8'h09, 8'h04
  };

  localparam logic [8*15-1:0] STR_TEXT [`STR_COUNT] = '{
    "Hobbyist", "TinyDFU Boot", "123456", "Flash"
  };
  localparam logic [7:0] STR_LEN [`STR_COUNT] = '{
    8'(`STR1_LEN), 8'(`STR2_LEN), 8'(`STR3_LEN), 8'(`STR4_LEN)
  };

  logic [7:0]  ep_rom [`EP_ROM_DEPTH];
  logic [7:0]  str_rom [`STR_ROM_DEPTH];
  usb_ctrl_pkg::reply_req_t sel;
  usb_ctrl_pkg::reply_src_e src;
  logic [7:0]  addr;
  logic [15:0] count;
  logic        all_sent_q;
  logic [7:0]  dfu_byte;

  initial begin
    int base;
    int nchar;
    for (int i = 0; i < `EP_ROM_DEPTH; i++) begin
      ep_rom[i] = (i < EP_IMG_LEN) ? EP_IMG[8*(EP_IMG_LEN-1-i) +: 8] : 8'h00;
    end
    for (int i = 0; i < `STR_ROM_DEPTH; i++) str_rom[i] = 8'h00;
    for (int s = 0; s < `STR_COUNT; s++) begin
      base = s * `STR_SLOT;
      nchar = (STR_LEN[s] - 2) / 2;
      str_rom[base] = STR_LEN[s];
      str_rom[base+1] = 8'h03;   // string type
      for (int k = 0; k < nchar; k++) begin
        str_rom[base+2+2*k] = STR_TEXT[s][8*(nchar-1-k) +: 8];   // utf-16, high byte zero
      end
    end
  end

  ////////////////////////////////////////
  // reply latch and byte counter
  ////////////////////////////////////////

  assign sel = std_reply.claim ? std_reply : (dfu_reply.claim ? dfu_reply : '0);

  assign all_sent = stage == usb_ctrl_pkg::DATA_IN && count == 16'd0;
  assign in_ep_req = stage == usb_ctrl_pkg::DATA_IN && count != 16'd0;
  assign in_ep_data_put = in_ep_req && in_ep.data_free;
  assign in_ep_data_done = (all_sent && !all_sent_q) || zlp;

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= 16'd0;
      stall <= 1'b0;
      all_sent_q <= 1'b0;
    end else begin
      stall <= setup_done && sel.stall;
      all_sent_q <= all_sent;
      if (setup_done) begin
        count <= sel.length;
      end else if (in_ep_data_put && in_ep.grant) begin
        count <= count - 16'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_done) begin
      src <= sel.src;
      addr <= sel.start_addr;
    end else if (in_ep_data_put && in_ep.grant) begin
      addr <= addr + 8'd1;
    end
  end

  // getstatus record: bStatus, bwPollTimeout = 1, bState, iString
  always_comb begin
    case (addr[2:0])
      3'd0: dfu_byte = dfu_status.b_status;
      3'd1: dfu_byte = 8'd1;
      3'd4: dfu_byte = dfu_status.b_state;
      default: dfu_byte = 8'd0;
    endcase
  end

  always_comb begin
    case (src)
      usb_ctrl_pkg::SRC_DESC: in_ep_data = ep_rom[addr[5:0]];
      usb_ctrl_pkg::SRC_STRING: in_ep_data = str_rom[addr[6:0]];
      usb_ctrl_pkg::SRC_DFU: in_ep_data = dfu_byte;
      default: in_ep_data = 8'h00;
    endcase
  end

endmodule

`default_nettype wire

/* hdl/setup_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_defines.svh"

module setup_capture (
  input  logic                     clk,
  input  logic                     reset,
  input  usb_ctrl_pkg::out_ep_t    out_ep,
  input  logic                     status_done,
  output usb_ctrl_pkg::setup_pkt_t setup
);

  logic       setup_valid;   // byte on out_ep.data this cycle
  logic [3:0] idx;
  logic [7:0] raw [`USB_SETUP_BYTES];

  always_ff @(posedge clk) begin
    if (reset) begin
      setup_valid <= 1'b0;
      idx <= 4'd0;
    end else begin
      setup_valid <= out_ep.data_avail && out_ep.grant && out_ep.setup;
      if (status_done) begin
        idx <= 4'd0;
      end else if (setup_valid && idx < 4'(`USB_SETUP_BYTES)) begin
        idx <= idx + 4'd1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (setup_valid && idx < 4'(`USB_SETUP_BYTES)) begin
      raw[idx[2:0]] <= out_ep.data;
    end
  end

  // bytes 2..7 are little endian words
  assign setup = {raw[0], raw[1], raw[3], raw[2], raw[5], raw[4], raw[7], raw[6]};

endmodule

`default_nettype wire

/* hdl/std_request_unit.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_defines.svh"

module std_request_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  usb_ctrl_pkg::setup_pkt_t setup,
  input  logic                     setup_done,
  input  logic                     status_done,
  output usb_ctrl_pkg::reply_req_t reply,
  output logic [6:0]               dev_addr
);

  logic [15:0] full_len;
  logic        pend_valid;
  logic [6:0]  pend_addr;

  always_comb begin
    reply = '0;
    full_len = 16'd0;
    reply.claim = setup.bm_request_type[6:5] == 2'b00;   // type standard
    case (usb_ctrl_pkg::std_request_e'(setup.b_request))
      usb_ctrl_pkg::GET_DESCRIPTOR: begin
        case (setup.w_value[15:8])
          8'd1: begin   // device
            reply.start_addr = `DESC_DEV_OFS;
            full_len = `DESC_DEV_LEN;
          end
          8'd2: begin   // configuration, whole set
            reply.start_addr = `DESC_CFG_OFS;
            full_len = `DESC_CFG_LEN;
          end
          8'd3: begin
            if (setup.w_value[7:0] == 8'd0) begin
              reply.start_addr = `DESC_LANG_OFS;
              full_len = `DESC_LANG_LEN;
            end else begin
              reply.src = usb_ctrl_pkg::SRC_STRING;
              reply.start_addr = 8'((setup.w_value[7:0] - 8'd1) * `STR_SLOT);
              case (setup.w_value[7:0])
                8'd1: full_len = `STR1_LEN;
                8'd2: full_len = `STR2_LEN;
                8'd3: full_len = `STR3_LEN;
                8'd4: full_len = `STR4_LEN;
                default: full_len = 16'd0;   // beyond STR_COUNT
              endcase
            end
          end
          8'd6: reply.stall = 1'b1;   // device qualifier, full speed only
          default: full_len = 16'd0;
        endcase
      end
      usb_ctrl_pkg::SET_ADDRESS,
      usb_ctrl_pkg::SET_CONFIGURATION,
      usb_ctrl_pkg::SET_INTERFACE: full_len = 16'd0;   // status stage only
      default: full_len = 16'd0;
    endcase
    reply.length = (full_len > setup.w_length) ? setup.w_length : full_len;
  end

  ////////////////////////////////////////
  // device address
  ////////////////////////////////////////

  // status stage still runs on the old address, so commit after it
  always_ff @(posedge clk) begin
    if (reset) begin
      pend_valid <= 1'b0;
      dev_addr <= 7'd0;
    end else if (setup_done && reply.claim && setup.b_request == usb_ctrl_pkg::SET_ADDRESS) begin
      pend_valid <= 1'b1;
    end else if (status_done && pend_valid) begin
      pend_valid <= 1'b0;
      dev_addr <= pend_addr;
    end
  end

  always_ff @(posedge clk) begin
    if (setup_done) pend_addr <= setup.w_value[6:0];
  end

endmodule

`default_nettype wire

/* hdl/usb_ctrl_pkg.sv */
`default_nettype none

package usb_ctrl_pkg;

  ////////////////////////////////////////
  // endpoint side
  ////////////////////////////////////////

  typedef struct packed {
    logic       grant;
    logic       data_avail;
    logic       setup;        // current packet is a setup packet
    logic [7:0] data;
    logic       acked;
  } out_ep_t;

  typedef struct packed {
    logic grant;
    logic data_free;
    logic acked;
  } in_ep_t;

  // fields in wire order, multi-byte fields little endian on the bus
  typedef struct packed {
    logic [7:0]  bm_request_type;
    logic [7:0]  b_request;
    logic [15:0] w_value;
    logic [15:0] w_index;
    logic [15:0] w_length;
  } setup_pkt_t;

  typedef enum logic [2:0] {
    IDLE,
    SETUP_IN,
    SETUP_DONE,
    DATA_IN,
    DATA_OUT,
    STATUS_IN,
    STATUS_OUT
  } ctrl_stage_e;

  typedef enum logic [7:0] {
    GET_STATUS        = 8'h00,
    CLEAR_FEATURE     = 8'h01,
    SET_FEATURE       = 8'h03,
    SET_ADDRESS       = 8'h05,
    GET_DESCRIPTOR    = 8'h06,
    GET_CONFIGURATION = 8'h08,
    SET_CONFIGURATION = 8'h09,
    GET_INTERFACE     = 8'h0a,
    SET_INTERFACE     = 8'h0b
  } std_request_e;

  ////////////////////////////////////////
  // reply from a request decoder
  ////////////////////////////////////////

  typedef enum logic [1:0] {
    SRC_DESC,
    SRC_STRING,
    SRC_DFU
  } reply_src_e;

  typedef struct packed {
    logic        claim;
    reply_src_e  src;
    logic [7:0]  start_addr;
    logic [15:0] length;      // already clipped to w_length
    logic        stall;
  } reply_req_t;

endpackage

`default_nettype wire

/* hdl/usb_dfu_ctrl_ep.sv */
`timescale 1ns/1ps
`default_nettype none

module usb_dfu_ctrl_ep (
  input  logic                  clk,
  input  logic                  reset,
  input  usb_ctrl_pkg::out_ep_t out_ep,
  input  usb_ctrl_pkg::in_ep_t  in_ep,
  output logic                  out_ep_req,
  output logic                  out_ep_data_get,
  output logic                  out_ep_stall,
  output logic                  in_ep_req,
  output logic                  in_ep_data_put,
  output logic [7:0]            in_ep_data,
  output logic                  in_ep_data_done,
  output logic                  in_ep_stall,
  output logic [6:0]            dev_addr
);

  usb_ctrl_pkg::setup_pkt_t  setup;
  usb_ctrl_pkg::ctrl_stage_e stage;
  usb_ctrl_pkg::reply_req_t  std_reply;
  usb_ctrl_pkg::reply_req_t  dfu_reply;
  dfu_pkg::dfu_status_rec_t  dfu_status;
  logic setup_done;
  logic status_done;
  logic zlp;
  logic all_sent;

  assign out_ep_req = out_ep.data_avail;
  assign out_ep_data_get = out_ep.data_avail;   // OUT data always drained
  assign out_ep_stall = 1'b0;

  setup_capture u_setup_capture (
    .clk(clk), .reset(reset), .out_ep(out_ep), .status_done(status_done), .setup(setup)
  );

  ctrl_stage_fsm u_ctrl_stage_fsm (
    .clk(clk), .reset(reset), .out_ep(out_ep), .in_ep(in_ep), .setup(setup),
    .all_sent(all_sent), .stall(in_ep_stall), .stage(stage),
    .setup_done(setup_done), .status_done(status_done), .zlp(zlp)
  );

  std_request_unit u_std_request_unit (
    .clk(clk), .reset(reset), .setup(setup), .setup_done(setup_done),
    .status_done(status_done), .reply(std_reply), .dev_addr(dev_addr)
  );

  dfu_request_unit u_dfu_request_unit (
    .clk(clk), .reset(reset), .setup(setup), .setup_done(setup_done),
    .reply(dfu_reply), .status(dfu_status)
  );

  reply_streamer u_reply_streamer (
    .clk(clk), .reset(reset), .stage(stage), .setup_done(setup_done), .zlp(zlp),
    .std_reply(std_reply), .dfu_reply(dfu_reply), .dfu_status(dfu_status),
    .in_ep(in_ep), .all_sent(all_sent), .stall(in_ep_stall),
    .in_ep_req(in_ep_req), .in_ep_data_put(in_ep_data_put),
    .in_ep_data(in_ep_data), .in_ep_data_done(in_ep_data_done)
  );

endmodule

`default_nettype wire

/* hdl/usb_dfu_defines.svh */
`ifndef USB_DFU_DEFINES_SVH
`define USB_DFU_DEFINES_SVH

// setup packet and endpoint sizes
`define USB_SETUP_BYTES 8
`define USB_MAX_PKT     32
`define DFU_XFER_SIZE   256   // wTransferSize in the functional descriptor

// rom geometry
`define STR_SLOT      32   // bytes per string descriptor slot
`define EP_ROM_DEPTH  64
`define STR_ROM_DEPTH 128

// descriptor placement in the endpoint rom
`define DESC_DEV_OFS  8'h00
`define DESC_CFG_OFS  8'h12
`define DESC_LANG_OFS 8'h2d
`define DESC_DEV_LEN  16'd18
`define DESC_CFG_LEN  16'd27   // config + interface + dfu functional
`define DESC_LANG_LEN 16'd4

// string descriptors, index 1 .. STR_COUNT
`define STR_COUNT 4
`define STR1_LEN  16'd18   // manufacturer
`define STR2_LEN  16'd26   // product
`define STR3_LEN  16'd14   // serial number
`define STR4_LEN  16'd12   // interface name

`endif

/* verif/tb_usb_dfu_ctrl_ep.sv */
`timescale 1ns/1ps
`default_nettype none

`include "usb_dfu_defines.svh"

module tb_usb_dfu_ctrl_ep;

  localparam int CYCLES_PER_CASE = 400;

  logic                  clk;
  logic                  reset;
  usb_ctrl_pkg::out_ep_t out_ep;
  usb_ctrl_pkg::in_ep_t  in_ep;
  logic                  out_ep_req;
  logic                  out_ep_data_get;
  logic                  out_ep_stall;
  logic                  in_ep_req;
  logic                  in_ep_data_put;
  logic [7:0]            in_ep_data;
  logic                  in_ep_data_done;
  logic                  in_ep_stall;
  logic [6:0]            dev_addr;

  // case table, setup byte 0 in the top bits
  string       case_name [$];
  logic [63:0] case_setup [$];
  logic        case_bp [$];
  int          case_len [$];
  logic        case_stall [$];
  logic [6:0]  case_addr [$];
  logic [63:0] case_exp [$];

  logic [7:0]  rx_bytes [$];
  logic [7:0]  ref_bytes [$];   // last reply without back-pressure
  logic [63:0] ref_setup;
  int          done_cnt;
  int          stall_cnt;
  int          offer_cnt;   // cycles with a byte offered and room for it
  int          hold_cnt;    // cycles with a byte waiting for room
  logic [6:0]  addr_at_ack;
  logic [6:0]  addr_seen;
  int          case_total;
  int          err_count;
  string       cur_name;

  usb_dfu_ctrl_ep DUT (
    .clk(clk), .reset(reset), .out_ep(out_ep), .in_ep(in_ep),
    .out_ep_req(out_ep_req), .out_ep_data_get(out_ep_data_get), .out_ep_stall(out_ep_stall),
    .in_ep_req(in_ep_req), .in_ep_data_put(in_ep_data_put), .in_ep_data(in_ep_data),
    .in_ep_data_done(in_ep_data_done), .in_ep_stall(in_ep_stall), .dev_addr(dev_addr)
  );

  always #50 clk = ~clk;

  // host side monitor, outputs are stable at the falling edge
  always @(negedge clk) begin
    addr_seen = dev_addr;
    check_value("out_ep_req", out_ep.data_avail, out_ep_req);
    check_value("out_ep_data_get", out_ep.data_avail, out_ep_data_get);
    if (in_ep_data_put && in_ep.grant) rx_bytes.push_back(in_ep_data);   // byte moves
    if (in_ep_req && in_ep.data_free) offer_cnt++;
    if (in_ep_req && !in_ep.data_free) hold_cnt++;
    if (in_ep_stall) stall_cnt++;
    if (in_ep_data_done) done_cnt++;
    if (in_ep.acked || out_ep.acked) addr_at_ack = dev_addr;   // last ack is the status one
  end

  task automatic fail_run();
    $display("Done: errors found");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_value(input string what, input int expected, input int actual);
    if (expected !== actual) begin
      err_count++;
      $display("ERR %s %s: expected 0x%0h, actual 0x%0h", cur_name, what, expected, actual);
      fail_run();
    end
  endtask

  ////////////////////////////////////////
  // case file
  ////////////////////////////////////////

  task automatic load_cases();
    int          fd;
    int          n;
    int          i;
    int          v [20];
    string       line;
    string       name;
    logic [63:0] setup;
    logic [63:0] expv;
    fd = $fopen("verif/usb_dfu_cases.txt", "r");
    if (fd == 0) begin
      $display("cannot open the case file verif/usb_dfu_cases.txt");
      fail_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin
          n = $sscanf(line, "%s %h %h %h %h %h %h %h %h %d %d %d %h %h %h %h %h %h %h %h %h",
                      name, v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9],
                      v[10], v[11], v[12], v[13], v[14], v[15], v[16], v[17], v[18], v[19]);
          if (n != 21) begin
            $display("malformed line in the case file: %s", line);
            fail_run();
          end else begin
            setup = '0;
            expv = '0;
            for (i = 0; i < `USB_SETUP_BYTES; i++) begin
              setup = (setup << 8) | 64'(v[i][7:0]);
              expv = (expv << 8) | 64'(v[12+i][7:0]);
            end
            if (!setup[63] && {setup[7:0], setup[15:8]} != 16'd0) begin
              $display("case %s asks for an OUT data stage, which the host model lacks", name);
              fail_run();
            end else begin
              case_name.push_back(name);
              case_setup.push_back(setup);
              case_bp.push_back(v[8] != 0);
              case_len.push_back(v[9]);
              case_stall.push_back(v[10] != 0);
              case_addr.push_back(v[11][6:0]);
              case_exp.push_back(expv);
            end
          end
        end
      end
      $fclose(fd);
    end
  endtask

  ////////////////////////////////////////
  // host endpoint model
  ////////////////////////////////////////

  task automatic send_setup(input logic [63:0] s);
    int i;
    @(posedge clk);
    out_ep.data_avail <= 1'b1;
    out_ep.grant <= 1'b1;
    out_ep.setup <= 1'b1;
    for (i = 0; i < `USB_SETUP_BYTES; i++) begin
      @(posedge clk);
      out_ep.data <= s[63-8*i -: 8];   // byte lands the cycle after get
      if (i == `USB_SETUP_BYTES - 1) begin
        out_ep.data_avail <= 1'b0;
        out_ep.grant <= 1'b0;
      end
    end
    @(posedge clk);
    out_ep.setup <= 1'b0;
  endtask

  task automatic run_case(input int k, input logic [6:0] prev_addr);
    logic [63:0] s;
    logic [15:0] wlen;
    logic        data_in;
    int          nchk;
    int          i;
    s = case_setup[k];
    wlen = {s[7:0], s[15:8]};
    data_in = s[63] && wlen != 16'd0;
    cur_name = case_name[k];
    rx_bytes.delete();
    done_cnt = 0;
    stall_cnt = 0;
    offer_cnt = 0;
    hold_cnt = 0;
    in_ep.grant <= data_in;
    send_setup(s);
    while (done_cnt == 0 && stall_cnt == 0) begin
      @(posedge clk);
      in_ep.data_free <= case_bp[k] ? 1'($urandom % 2) : 1'b1;
    end
    in_ep.data_free <= 1'b1;
    if (stall_cnt == 0) begin
      in_ep.acked <= 1'b1;   // data or zero length status packet acked
      @(posedge clk);
      in_ep.acked <= 1'b0;
      if (data_in) begin
        out_ep.acked <= 1'b1;   // empty OUT status packet
        @(posedge clk);
        out_ep.acked <= 1'b0;
      end
      check_value("dev_addr during status ack", prev_addr, addr_at_ack);
    end
    in_ep.grant <= 1'b0;
    repeat (4) @(posedge clk);
    check_value("reply length", case_len[k], rx_bytes.size());
    check_value("cycles with a byte offered", case_len[k], offer_cnt);
    check_value("stall", case_stall[k], stall_cnt != 0);
    check_value("done pulses", 1, done_cnt);
    check_value("dev_addr", case_addr[k], addr_seen);
    check_value("out_ep_stall", 0, out_ep_stall);
    nchk = (case_len[k] < 8) ? case_len[k] : 8;
    for (i = 0; i < nchk; i++) begin
      check_value($sformatf("byte %0d", i), case_exp[k][63-8*i -: 8], rx_bytes[i]);
    end
    if (case_bp[k]) begin
      if (ref_setup !== s) begin
        $display("back-pressure case %s has no matching case without back-pressure", cur_name);
        fail_run();
      end else if (hold_cnt == 0) begin
        $display("back-pressure case %s never had a byte held back", cur_name);
        fail_run();
      end else begin
        check_value("length against reference", ref_bytes.size(), rx_bytes.size());
        for (i = 0; i < ref_bytes.size(); i++) begin
          check_value($sformatf("byte %0d against reference", i), ref_bytes[i], rx_bytes[i]);
        end
      end
    end else if (rx_bytes.size() > 0) begin
      ref_setup = s;
      ref_bytes = rx_bytes;
    end
  endtask

  ////////////////////////////////////////
  // main sequence and watchdog
  ////////////////////////////////////////

  initial begin : main
    int         k;
    logic [6:0] prev_addr;
    clk = 1'b0;
    reset = 1'b1;
    out_ep = '0;
    in_ep = '0;
    in_ep.data_free = 1'b1;
    done_cnt = 0;
    stall_cnt = 0;
    offer_cnt = 0;
    hold_cnt = 0;
    err_count = 0;
    case_total = 0;
    ref_setup = '0;
    addr_at_ack = '0;
    addr_seen = '0;
    cur_name = "reset";
    void'($urandom(83644));
    load_cases();
    if (case_name.size() == 0) begin
      $display("the case file holds no cases");
      fail_run();
    end else begin
      case_total = case_name.size();
      repeat (16) @(posedge clk);
      reset <= 1'b0;
      @(negedge clk);
      check_value("in_ep_req", 0, in_ep_req);
      check_value("in_ep_data_put", 0, in_ep_data_put);
      check_value("in_ep_data_done", 0, in_ep_data_done);
      check_value("in_ep_stall", 0, in_ep_stall);
      check_value("dev_addr", 0, dev_addr);
      @(posedge clk);
      prev_addr = 7'd0;
      for (k = 0; k < case_total; k++) begin
        run_case(k, prev_addr);
        prev_addr = case_addr[k];
      end
      if (err_count == 0) begin
        $display("Done: no errors");
        $finish;
      end else begin
        fail_run();
      end
    end
  end

  initial begin : watchdog
    wait (case_total > 0);
    repeat (case_total * CYCLES_PER_CASE) @(posedge clk);
    $display("watchdog expired, the cases did not finish within %0d cycles",
             case_total * CYCLES_PER_CASE);
    fail_run();
  end

endmodule

`default_nettype wire

/* verif/usb_dfu_cases.txt */
# name  setup bytes 0..7 (hex)  backpressure len stall (dec)  dev_addr after (hex)
# first reply bytes 0..7 (hex), only the first min(len, 8) are compared
dev_desc_8      80 06 00 01 00 00 08 00  0  8 0 00  12 01 00 01 00 00 00 20
dev_desc_64     80 06 00 01 00 00 40 00  0 18 0 00  12 01 00 01 00 00 00 20
dev_desc_bp     80 06 00 01 00 00 40 00  1 18 0 00  12 01 00 01 00 00 00 20
cfg_desc        80 06 00 02 00 00 ff 00  0 27 0 00  09 02 1b 00 01 01 00 c0
lang_desc       80 06 00 03 00 00 ff 00  0  4 0 00  04 03 09 04 00 00 00 00
str2_desc       80 06 02 03 09 04 ff 00  0 26 0 00  1a 03 54 00 69 00 6e 00
str2_desc_bp    80 06 02 03 09 04 ff 00  1 26 0 00  1a 03 54 00 69 00 6e 00
str1_short      80 06 01 03 09 04 04 00  0  4 0 00  12 03 48 00 00 00 00 00
set_address     00 05 2a 00 00 00 00 00  0  0 0 2a  00 00 00 00 00 00 00 00
dev_after_addr  80 06 00 01 00 00 12 00  0 18 0 2a  12 01 00 01 00 00 00 20
set_config      00 09 01 00 00 00 00 00  0  0 0 2a  00 00 00 00 00 00 00 00
set_interface   01 0b 00 00 00 00 00 00  0  0 0 2a  00 00 00 00 00 00 00 00
dev_qualifier   80 06 00 06 00 00 0a 00  0  0 1 2a  00 00 00 00 00 00 00 00
dfu_status_ok   a1 03 00 00 00 00 06 00  0  6 0 2a  00 01 00 00 02 00 00 00
dfu_dnload      21 01 00 00 00 00 00 00  0  0 1 2a  00 00 00 00 00 00 00 00
dfu_status_err  a1 03 00 00 00 00 06 00  0  6 0 2a  0f 01 00 00 0a 00 00 00
dfu_state_err   a1 05 00 00 00 00 01 00  0  1 0 2a  0a 00 00 00 00 00 00 00
dfu_clrstatus   21 04 00 00 00 00 00 00  0  0 0 2a  00 00 00 00 00 00 00 00
dfu_state_idle  a1 05 00 00 00 00 01 00  0  1 0 2a  02 00 00 00 00 00 00 00
dfu_upload      a1 02 00 00 00 00 40 00  0  0 1 2a  00 00 00 00 00 00 00 00
dfu_state_err2  a1 05 00 00 00 00 01 00  0  1 0 2a  0a 00 00 00 00 00 00 00
dfu_abort       21 06 00 00 00 00 00 00  0  0 0 2a  00 00 00 00 00 00 00 00
dfu_status_abrt a1 03 00 00 00 00 06 00  0  6 0 2a  0f 01 00 00 02 00 00 00
dfu_status_shrt a1 03 00 00 00 00 03 00  0  3 0 2a  0f 01 00 00 00 00 00 00

/* vlog.f */
+incdir+hdl
hdl/usb_ctrl_pkg.sv
hdl/dfu_pkg.sv
hdl/setup_capture.sv
hdl/ctrl_stage_fsm.sv
hdl/std_request_unit.sv
hdl/dfu_request_unit.sv
hdl/reply_streamer.sv
hdl/usb_dfu_ctrl_ep.sv
verif/tb_usb_dfu_ctrl_ep.sv
